//--- hdl/data_memory.sv
`timescale 1ns/1ps

module data_memory
  import hack_isa_pkg::*;
  import hack_mem_pkg::*;
#(
  parameter int unsigned ram_addr_bits = 14
) (
  input  logic      clk,
  input  logic      reset,
  input  mem_req_t  mem_req,
  output word_t     rdata,
  output logic      busy,
  input  logic      video_req,
  input  mem_addr_t video_addr,
  output word_t     video_data
);

  localparam int unsigned ram_words  = 1 << ram_addr_bits;
  localparam int unsigned vram_words = int'(vram_last - vram_base) + 1;

  word_t ram  [ram_words];
  word_t vram [vram_words];

  logic        cpu_in_vram;
  vram_index_t cpu_vram_idx;

  // two-stage read path for the CPU side of video RAM
  word_t vram_rd_q1;
  word_t vram_rd_q2;

  assign cpu_in_vram  = is_vram(mem_req.addr);
  assign cpu_vram_idx = vram_offset(mem_req.addr);

  // the video reader owns video RAM for as long as it requests it
  assign busy = cpu_in_vram && video_req;

  always_ff @(posedge clk) begin
    if (mem_req.load) begin
      if (cpu_in_vram) begin
        vram[cpu_vram_idx] <= mem_req.wdata;
      end else begin
        // addresses above video RAM fold back onto the fast RAM
        ram[mem_req.addr[ram_addr_bits-1:0]] <= mem_req.wdata;
      end
    end
  end

  // the first stage samples only while the reader is away
  // the second stage gives the CPU its two cycle count
  always_ff @(posedge clk) begin
    if (cpu_in_vram && !video_req) begin
      vram_rd_q1 <= vram[cpu_vram_idx];
    end
    vram_rd_q2 <= vram_rd_q1;
  end

  // fast RAM answers combinationally, video RAM from the pipeline end
  assign rdata = cpu_in_vram ? vram_rd_q2 : ram[mem_req.addr[ram_addr_bits-1:0]];

  // video_addr is a full data address inside the video RAM window
  // the reader sees zero until its first request after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      video_data <= '0;
    end else if (video_req) begin
      video_data <= vram[vram_offset(video_addr)];
    end
  end

endmodule

//--- hdl/hack_alu.sv
`timescale 1ns/1ps

module hack_alu
  import hack_isa_pkg::*;
(
  input  word_t     x,
  input  word_t     y,
  input  alu_ctrl_t ctrl,
  output word_t     result,
  output logic      zero,
  output logic      neg
);

  word_t x_zeroed;
  word_t x_final;
  word_t y_zeroed;
  word_t y_final;
  word_t f_out;

  always_comb begin
    // each operand can be forced to zero and then bitwise inverted
    x_zeroed = ctrl.zx ? '0 : x;
    x_final  = ctrl.nx ? ~x_zeroed : x_zeroed;
    y_zeroed = ctrl.zy ? '0 : y;
    y_final  = ctrl.ny ? ~y_zeroed : y_zeroed;

    // f picks the adder, otherwise the bitwise and
    f_out = ctrl.f ? (x_final + y_final) : (x_final & y_final);

    // the result itself can be inverted as the last step
    result = ctrl.no ? ~f_out : f_out;
  end

  // flags describe the final result, as the jump logic reads them
  assign zero = (result == '0);
  assign neg  = result[15];

endmodule

//--- hdl/hack_cpu.sv
`timescale 1ns/1ps

module hack_cpu
  import hack_isa_pkg::*;
  import hack_mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  word_t    instruction,
  output word_t    prog_counter,
  output mem_req_t mem_req,
  input  word_t    mem_rdata,
  input  logic     mem_busy
);

  cpu_state_t state;

  word_t a_reg;
  word_t d_reg;

  // operands and control bits latched during decode
  word_t     alu_x;
  word_t     alu_y;
  alu_ctrl_t ctrl_q;
  dest_t     dest_q;
  jump_t     jump_q;

  word_t alu_result;
  logic  alu_zero;
  logic  alu_neg;
  logic  take_jump;
  logic  fast_mem;
  logic  wb_ready;

  // counts the video RAM read latency once busy has dropped
  logic [1:0] mem_wait;

  hack_alu alu (
    .x      (alu_x),
    .y      (alu_y),
    .ctrl   (ctrl_q),
    .result (alu_result),
    .zero   (alu_zero),
    .neg    (alu_neg)
  );

  // anything outside video RAM is private to the CPU and answers at once
  assign fast_mem = !is_vram(a_reg);

  assign take_jump = (jump_q.lt && alu_neg) ||
                     (jump_q.eq && alu_zero) ||
                     (jump_q.gt && !alu_neg && !alu_zero);

  // write back may finish unless it stores to video RAM held by the reader
  assign wb_ready = !dest_q.m || fast_mem || !mem_busy;

  assign mem_req.addr  = a_reg;
  assign mem_req.wdata = alu_result;

  // the store strobe fires only in the cycle the write back completes
  assign mem_req.load = (state == write_back) && dest_q.m && wb_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= inst_fetch;
      prog_counter <= '0;
      a_reg        <= '0;
      d_reg        <= '0;
      mem_wait     <= '0;
    end else begin
      case (state)
        inst_fetch: begin
          // the ROM needs this cycle to present the word at prog_counter
          state <= inst_decode;
        end
        inst_decode: begin
          if (instruction[c_inst_bit]) begin
            ctrl_q <= alu_ctrl_t'(instruction[11:6]);
            dest_q <= dest_t'(instruction[5:3]);
            jump_q <= jump_t'(instruction[2:0]);
            alu_x  <= d_reg;
            if (instruction[a_sel_bit]) begin
              state <= mem_read;
            end else begin
              alu_y <= a_reg;
              state <= write_back;
            end
          end else begin
            a_reg <= instruction;
            state <= inst_fetch;
          end
          // step ahead now so the next word is already fetched when this one ends
          prog_counter <= prog_counter + 16'd1;
        end
        mem_read: begin
          if (fast_mem) begin
            state <= mem_fetch;
          end else begin
            // video RAM data arrives two cycles after the reader lets go
            case (mem_wait)
              2'd0: mem_wait <= mem_busy ? 2'd0 : 2'd1;
              2'd1: mem_wait <= 2'd2;
              default: state <= mem_fetch;
            endcase
          end
        end
        mem_fetch: begin
          mem_wait <= '0;
          alu_y    <= mem_rdata;
          state    <= write_back;
        end
        write_back: begin
          if (wb_ready) begin
            if (dest_q.a) begin
              a_reg <= alu_result;
            end
            if (dest_q.d) begin
              d_reg <= alu_result;
            end
            // a taken jump drops the speculative address and refetches
            if (take_jump) begin
              prog_counter <= a_reg;
              state        <= inst_fetch;
            end else begin
              state <= inst_decode;
            end
          end
        end
        default: begin
          state <= inst_fetch;
        end
      endcase
    end
  end

endmodule

//--- hdl/hack_isa_pkg.sv
package hack_isa_pkg;

  // one machine word, used for data and for instructions alike
  typedef logic [15:0] word_t;

  // bit 15 tells a C-instruction (set) from an A-instruction (clear)
  localparam int unsigned c_inst_bit = 15;

  // bit 12 selects memory rather than the A register as the y operand
  localparam int unsigned a_sel_bit = 12;

  // ALU control field, instruction bits 11 down to 6
  typedef struct packed {
    logic zx;
    logic nx;
    logic zy;
    logic ny;
    logic f;
    logic no;
  } alu_ctrl_t;

  // destination field, instruction bits 5 down to 3
  typedef struct packed {
    logic a;
    logic d;
    logic m;
  } dest_t;

  // jump field, instruction bits 2 down to 0
  typedef struct packed {
    logic lt;
    logic eq;
    logic gt;
  } jump_t;

  // CPU sequencer states
  typedef enum logic [2:0] {
    inst_fetch,
    inst_decode,
    mem_read,
    mem_fetch,
    write_back
  } cpu_state_t;

endpackage

//--- hdl/hack_mem_pkg.sv
package hack_mem_pkg;

  import hack_isa_pkg::*;

  // data address as driven by the A register
  typedef logic [15:0] mem_addr_t;

  // word offset inside video RAM, 8K words
  typedef logic [12:0] vram_index_t;

  // shared video RAM window in the data address space
  localparam mem_addr_t vram_base = 16'h4000;
  localparam mem_addr_t vram_last = 16'h5fff;

  // data request from the CPU, load writes wdata at addr on the clock edge
  typedef struct packed {
    mem_addr_t addr;
    word_t     wdata;
    logic      load;
  } mem_req_t;

  // true when the address falls in the shared video RAM window
  function automatic logic is_vram(mem_addr_t addr);
    return (addr >= vram_base) && (addr <= vram_last);
  endfunction

  // word offset of a video RAM address relative to the window base
  function automatic vram_index_t vram_offset(mem_addr_t addr);
    mem_addr_t offset;
    offset = addr - vram_base;
    return offset[12:0];
  endfunction

endpackage

//--- hdl/hack_system.sv
`timescale 1ns/1ps

module hack_system
  import hack_isa_pkg::*;
  import hack_mem_pkg::*;
#(
  parameter int unsigned rom_addr_bits = 10,
  parameter int unsigned ram_addr_bits = 14
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      prog_we,
  input  word_t     prog_addr,
  input  word_t     prog_data,
  input  logic      video_req,
  input  mem_addr_t video_addr,
  output word_t     video_data,
  output word_t     prog_counter
);

  word_t    instruction;
  mem_req_t mem_req;
  word_t    mem_rdata;
  logic     mem_busy;

  // program store, addressed by the CPU program counter
  instruction_rom #(
    .rom_addr_bits (rom_addr_bits)
  ) rom (
    .clk         (clk),
    .addr        (prog_counter),
    .instruction (instruction),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data)
  );

  hack_cpu cpu (
    .clk          (clk),
    .reset        (reset),
    .instruction  (instruction),
    .prog_counter (prog_counter),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .mem_busy     (mem_busy)
  );

  // fast RAM and the video RAM shared with the external reader
  data_memory #(
    .ram_addr_bits (ram_addr_bits)
  ) dmem (
    .clk        (clk),
    .reset      (reset),
    .mem_req    (mem_req),
    .rdata      (mem_rdata),
    .busy       (mem_busy),
    .video_req  (video_req),
    .video_addr (video_addr),
    .video_data (video_data)
  );

endmodule

//--- hdl/instruction_rom.sv
`timescale 1ns/1ps

module instruction_rom
  import hack_isa_pkg::*;
#(
  parameter int unsigned rom_addr_bits = 10
) (
  input  logic  clk,
  input  word_t addr,
  output word_t instruction,
  input  logic  prog_we,
  input  word_t prog_addr,
  input  word_t prog_data
);

  localparam int unsigned rom_words = 1 << rom_addr_bits;

  word_t rom [rom_words];

  // the load port writes one word per strobe and is used only under reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      rom[prog_addr[rom_addr_bits-1:0]] <= prog_data;
    end
  end

  // registered read, the word appears one cycle after its address
  // upper address bits wrap onto the array
  always_ff @(posedge clk) begin
    instruction <= rom[addr[rom_addr_bits-1:0]];
  end

endmodule

//--- run.sh
#!/bin/sh
# builds the Hack system testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module hack_system_tb \
  -o sim_hack_system > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_hack_system > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi

//--- src.f
hdl/hack_isa_pkg.sv
hdl/hack_mem_pkg.sv
hdl/hack_alu.sv
hdl/hack_cpu.sv
hdl/instruction_rom.sv
hdl/data_memory.sv
hdl/hack_system.sv
tests/hack_system_assertions.sv
tests/hack_system_tb.sv

//--- tests/hack_system_assertions.sv
`timescale 1ns/1ps

module hack_system_assertions
  import hack_isa_pkg::*;
  import hack_mem_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input cpu_state_t state,
  input mem_req_t   mem_req,
  input dest_t      dest_q,
  input logic       mem_busy,
  input word_t      prog_counter
);

  logic wb_stall;

  // number of assertion failures seen so far
  int fail_count = 0;

  // a store to video RAM waits in write back while the reader owns it
  assign wb_stall = (state == write_back) && dest_q.m && mem_busy;

  // a store happens only in a write back that the video reader does not hold up
  load_only_in_write_back: assert property (@(posedge clk) disable iff (reset)
    mem_req.load |-> (state == write_back) && !mem_busy)
    else begin
      fail_count++;
      $error("memory store strobe seen outside a free write back");
    end

  // back-pressure freezes the program counter
  pc_stable_on_stall: assert property (@(posedge clk) disable iff (reset)
    wb_stall |=> prog_counter == $past(prog_counter))
    else begin
      fail_count++;
      $error("program counter moved while write back was stalled");
    end

  // the stalled store is retried and the FSM does not move on
  stall_keeps_write_back: assert property (@(posedge clk) disable iff (reset)
    wb_stall |=> state == write_back)
    else begin
      fail_count++;
      $error("FSM left write back while the store was stalled");
    end

endmodule

bind hack_cpu hack_system_assertions cpu_checks (
  .clk          (clk),
  .reset        (reset),
  .state        (state),
  .mem_req      (mem_req),
  .dest_q       (dest_q),
  .mem_busy     (mem_busy),
  .prog_counter (prog_counter)
);

//--- tests/hack_system_tb.sv
`timescale 1ns/1ps

module hack_system_tb
  import hack_isa_pkg::*;
  import hack_mem_pkg::*;
;

  // one table row holds operands, ALU code, jump bits and the y source
  typedef struct packed {
    word_t     x;
    word_t     y;
    alu_ctrl_t ctrl;
    jump_t     jump;
    logic      use_mem;
  } entry_t;

  // word the taken branch leaves in video RAM
  localparam word_t marker_word = 16'h0a5a;
  // fast RAM word that carries a memory operand
  localparam word_t operand_addr = 16'h0100;

  logic      clk = 1'b0;
  logic      reset;
  logic      prog_we;
  word_t     prog_addr;
  word_t     prog_data;
  logic      video_req;
  mem_addr_t video_addr;
  word_t     video_data;
  word_t     prog_counter;

  entry_t tbl[$];
  word_t  prog[$];
  int     errors;
  int     checks;
  int     cur_entry;

  hack_system #(
    .rom_addr_bits (10),
    .ram_addr_bits (14)
  ) uut (
    .clk          (clk),
    .reset        (reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .video_req    (video_req),
    .video_addr   (video_addr),
    .video_data   (video_data),
    .prog_counter (prog_counter)
  );

  always #4 clk = ~clk;

  // the Hack ALU zeroes and negates each operand, adds or ands, then negates the output
  function automatic word_t alu_rule(word_t x, word_t y, alu_ctrl_t c);
    word_t xv;
    word_t yv;
    word_t fv;
    xv = c.zx ? 16'h0000 : x;
    xv = c.nx ? ~xv : xv;
    yv = c.zy ? 16'h0000 : y;
    yv = c.ny ? ~yv : yv;
    fv = c.f ? (xv + yv) : (xv & yv);
    return c.no ? ~fv : fv;
  endfunction

  // a jump is taken when one of its bits matches the sign of the value
  function automatic logic jump_rule(word_t r, jump_t j);
    return (j.lt && r[15]) || (j.eq && r == 16'h0000) ||
           (j.gt && !r[15] && r != 16'h0000);
  endfunction

  task automatic check_value(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s (entry %0d): got %h, expected %h", name, cur_entry, got, exp);
    end
  endtask

  task automatic add_entry(word_t x, word_t y, logic [5:0] ctrl, logic [2:0] jump,
                           logic use_mem);
    entry_t e;
    e.x       = x;
    e.y       = y;
    e.ctrl    = alu_ctrl_t'(ctrl);
    e.jump    = jump_t'(jump);
    e.use_mem = use_mem;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    int unsigned k;
    // the eighteen standard computations with edge-case operands
    add_entry(16'h0000, 16'h0000, 6'b101010, 3'b010, 1'b0);
    add_entry(16'h1234, 16'h5678, 6'b111111, 3'b001, 1'b0);
    add_entry(16'h7fff, 16'h8000, 6'b111010, 3'b100, 1'b0);
    add_entry(16'h8000, 16'h0001, 6'b001100, 3'b011, 1'b0);
    add_entry(16'h00ff, 16'hff00, 6'b110000, 3'b101, 1'b1);
    add_entry(16'h5555, 16'haaaa, 6'b001101, 3'b110, 1'b0);
    add_entry(16'h0001, 16'hffff, 6'b110001, 3'b111, 1'b1);
    add_entry(16'h8000, 16'h0003, 6'b001111, 3'b100, 1'b0);
    add_entry(16'h1111, 16'h7fff, 6'b110011, 3'b001, 1'b1);
    add_entry(16'hffff, 16'h0000, 6'b011111, 3'b010, 1'b0);
    add_entry(16'h0010, 16'h7fff, 6'b110111, 3'b100, 1'b0);
    add_entry(16'h0000, 16'h4321, 6'b001110, 3'b100, 1'b1);
    add_entry(16'h2222, 16'h0000, 6'b110010, 3'b010, 1'b0);
    add_entry(16'h7fff, 16'h0001, 6'b000010, 3'b100, 1'b1);
    add_entry(16'h0005, 16'h0005, 6'b010011, 3'b010, 1'b0);
    add_entry(16'h0003, 16'h0009, 6'b000111, 3'b001, 1'b1);
    add_entry(16'hf0f0, 16'h0ff0, 6'b000000, 3'b101, 1'b0);
    add_entry(16'hf0f0, 16'h0ff0, 6'b010101, 3'b000, 1'b1);
    // rows 13 and 16 again with the other y source
    add_entry(16'h7fff, 16'h0001, 6'b000010, 3'b100, 1'b0);
    add_entry(16'hf0f0, 16'h0ff0, 6'b000000, 3'b101, 1'b1);
    // random operands on computations picked from the rows above
    for (int n = 0; n < 8; n++) begin
      k = $urandom_range(17, 0);
      add_entry(word_t'($urandom), word_t'($urandom), tbl[k].ctrl, 3'($urandom),
                1'($urandom));
    end
  endtask

  function automatic void emit(word_t w);
    prog.push_back(w);
  endfunction

  // A-instructions hold 15 bits, so a negative value goes in inverted
  function automatic void load_d_with(word_t v);
    emit(v[15] ? ~v : v);
    emit(v[15] ? 16'hec50 : 16'hec10);
  endfunction

  function automatic void load_a_with(word_t v);
    if (v[15]) begin
      emit(~v);
      emit(16'hec60);
    end else begin
      emit(v);
    end
  endfunction

  // compute, store the result, then branch to a marker store or skip it
  task automatic build_program(entry_t e, int idx, output word_t halt);
    word_t k;
    prog.delete();
    if (e.use_mem) begin
      // y is parked in fast RAM first since D is needed to move it
      load_a_with(e.y);
      emit(16'hec10);
      emit(operand_addr);
      emit(16'he308);
      load_d_with(e.x);
      emit(operand_addr);
    end else begin
      load_d_with(e.x);
      load_a_with(e.y);
    end
    emit({3'b111, e.use_mem, e.ctrl, 3'b010, 3'b000});
    emit(vram_base + word_t'(idx));
    emit(16'he308);
    // clear the marker so only a taken jump can set it
    emit(vram_base + 16'h0040 + word_t'(idx));
    emit(16'hea88);
    k = word_t'(prog.size());
    halt = k + 16'd8;
    emit(k + 16'd4);
    emit({3'b111, 1'b0, 6'b001100, 3'b000, e.jump});
    emit(halt);
    emit(16'hea87);
    emit(marker_word);
    emit(16'hec10);
    emit(vram_base + 16'h0040 + word_t'(idx));
    emit(16'he308);
    // the halt loop jumps to itself forever
    emit(halt);
    emit(16'hea87);
  endtask

  // the ROM is written while the CPU is held in reset
  task automatic load_and_release();
    reset = 1'b1;
    foreach (prog[j]) begin
      prog_we   = 1'b1;
      prog_addr = word_t'(j);
      prog_data = prog[j];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  // done once the program counter has stayed inside the halt loop for a while
  task automatic wait_for_halt(word_t halt, logic noise_on, output logic reached);
    int stable;
    reached = 1'b0;
    stable  = 0;
    for (int cyc = 0; cyc < 4000 && !reached; cyc++) begin
      @(negedge clk);
      video_req = noise_on ? 1'($urandom) : 1'b0;
      if (prog_counter >= halt && prog_counter <= halt + 16'd2) begin
        stable++;
      end else begin
        stable = 0;
      end
      if (stable >= 40) begin
        reached = 1'b1;
      end
    end
    video_req = 1'b0;
  endtask

  task automatic read_vram(mem_addr_t addr, output word_t data);
    video_req  = 1'b1;
    video_addr = addr;
    @(negedge clk);
    data      = video_data;
    video_req = 1'b0;
  endtask

  initial begin
    entry_t e;
    word_t  halt;
    word_t  got;
    word_t  res;
    logic   reached;
    int     assert_fails;
    reset      = 1'b1;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    video_req  = 1'b0;
    video_addr = vram_base;
    errors     = 0;
    checks     = 0;
    cur_entry  = 0;
    void'($urandom(32'hfbae1899));
    build_table();
    @(negedge clk);
    for (int i = 0; i < tbl.size(); i++) begin
      cur_entry = i;
      e = tbl[i];
      build_program(e, i, halt);
      load_and_release();
      // one cycle out of reset the first word is only being fetched
      @(negedge clk);
      check_value("prog_counter", prog_counter, 16'h0000);
      // odd entries run against a video reader that comes and goes
      wait_for_halt(halt, i[0], reached);
      if (!reached) begin
        errors++;
        $display("timeout: entry %0d never settled in its halt loop", i);
      end else begin
        res = alu_rule(e.x, e.y, e.ctrl);
        read_vram(vram_base + word_t'(i), got);
        check_value("result", got, res);
        read_vram(vram_base + 16'h0040 + word_t'(i), got);
        check_value("marker", got, jump_rule(res, e.jump) ? marker_word : 16'h0000);
      end
    end
    assert_fails = uut.cpu.cpu_checks.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
